//--- src/isa_pkg.sv
/*
 * Instruction set of the mini core, one 16-bit word per instruction.
 * Opcodes 9 to 15 are not defined and behave as no-ops.
 */
package isa_pkg;

    localparam int ILEN = 16;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        ADDI = 4'd3,
        LW   = 4'd4,
        SW   = 4'd5,
        BNEZ = 4'd6,
        WID  = 4'd7,
        HALT = 4'd8
    } opcode_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] rd;
        logic [2:0] rs1;
        logic [2:0] rs2;
        logic [2:0] pad;
    } r_fmt_t;

    typedef struct packed {
        opcode_e           opcode;
        logic [2:0]        rd;
        logic [2:0]        rs1;
        logic signed [5:0] imm;
    } i_fmt_t;

    // The same word seen as register or immediate format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef struct packed {
        opcode_e         opcode;
        logic [2:0]      rd;
        logic [2:0]      rs1;
        logic [2:0]      rs2;
        logic [ILEN-1:0] imm;
    } uop_t;

endpackage

//--- src/core_pkg.sv
/*
 * Core-level widths, configuration addresses and bus types.
 * Configuration address 3 is not decoded and writes to it are dropped.
 */
package core_pkg;

    localparam int XLEN       = 16;
    localparam int ADDR_W     = 8;
    localparam int PERF_W     = 32;
    localparam int DCR_ADDR_W = 2;

    localparam logic [DCR_ADDR_W-1:0] DCR_START_PC  = 2'd0;
    localparam logic [DCR_ADDR_W-1:0] DCR_WARP_MASK = 2'd1;
    localparam logic [DCR_ADDR_W-1:0] DCR_LAUNCH    = 2'd2;

    typedef struct packed {
        logic [DCR_ADDR_W-1:0] addr;
        logic [15:0]           data;
    } dcr_wr_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [XLEN-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic [PERF_W-1:0] ifetches;
        logic [PERF_W-1:0] loads;
        logic [PERF_W-1:0] stores;
        logic [PERF_W-1:0] ifetch_latency;
        logic [PERF_W-1:0] load_latency;
    } perf_t;

endpackage

//--- src/dcr_regs.sv
/*
 * Configuration registers. Only the low bits of the write data are kept.
 * The launch write carries no data and gives a one-cycle pulse.
 */
module dcr_regs #(
    parameter int NUM_WARPS = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        dcr_wr_valid,
    input  core_pkg::dcr_wr_t           dcr_wr,
    output logic [core_pkg::ADDR_W-1:0] start_pc,
    output logic [NUM_WARPS-1:0]        warp_mask,
    output logic                        launch
);
    import core_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            start_pc  <= '0;
            warp_mask <= '0;
            launch    <= 1'b0;
        end else begin
            launch <= dcr_wr_valid && (dcr_wr.addr == DCR_LAUNCH);
            if (dcr_wr_valid && (dcr_wr.addr == DCR_START_PC)) begin
                start_pc <= dcr_wr.data[ADDR_W-1:0];
            end
            if (dcr_wr_valid && (dcr_wr.addr == DCR_WARP_MASK)) begin
                warp_mask <= dcr_wr.data[NUM_WARPS-1:0];
            end
        end
    end

endmodule

//--- src/warp_sched.sv
/*
 * Warp scheduler with one instruction in flight.
 * A launch while busy is ignored. NUM_WARPS must be a power of two.
 */
module warp_sched #(
    parameter int NUM_WARPS = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [core_pkg::ADDR_W-1:0]  start_pc,
    input  logic [NUM_WARPS-1:0]         warp_mask,
    input  logic                         launch,
    input  isa_pkg::uop_t                uop,
    input  logic                         branch_taken,
    input  logic [core_pkg::ADDR_W-1:0]  branch_target,
    output logic                         imem_req_valid,
    output core_pkg::mem_req_t           imem_req,
    input  logic                         imem_req_ready,
    input  logic                         imem_rsp_valid,
    output logic                         dmem_req_valid,
    input  logic                         dmem_req_ready,
    input  logic                         dmem_rsp_valid,
    output logic                         fetch_done,
    output logic                         exec_en,
    output logic                         load_wb,
    output logic [$clog2(NUM_WARPS)-1:0] warp_id,
    output logic                         busy
);
    import core_pkg::*;
    import isa_pkg::*;

    localparam int WID_W = $clog2(NUM_WARPS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PICK,
        S_FETCH,
        S_EXEC,
        S_MEM
    } state_e;

    state_e               state;
    logic [ADDR_W-1:0]    pcs [NUM_WARPS];
    logic [NUM_WARPS-1:0] active;
    logic [WID_W-1:0]     next_warp;
    logic                 start;

    assign start      = launch && (state == S_IDLE);
    assign fetch_done = (state == S_FETCH) && imem_rsp_valid;
    assign exec_en    = (state == S_EXEC);
    assign load_wb    = (state == S_MEM) && (uop.opcode == LW) && dmem_rsp_valid;
    assign imem_req   = mem_req_t'{addr: pcs[warp_id], write: 1'b0, wdata: '0};

    // Scanning from the far end lets the nearest active warp above the last one win
    always_comb begin
        int idx;
        next_warp = warp_id;
        for (int i = NUM_WARPS; i >= 1; i--) begin
            idx = (int'(warp_id) + i) % NUM_WARPS;
            if (active[idx]) begin
                next_warp = WID_W'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= S_IDLE;
            active         <= '0;
            warp_id        <= '0;
            busy           <= 1'b0;
            imem_req_valid <= 1'b0;
            dmem_req_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        active  <= warp_mask;
                        // Start one below warp 0 so the first pick wraps to the lowest warp
                        warp_id <= WID_W'(NUM_WARPS - 1);
                        busy    <= 1'b1;
                        state   <= S_PICK;
                    end
                end
                S_PICK: begin
                    if (active == '0) begin
                        busy  <= 1'b0;
                        state <= S_IDLE;
                    end else begin
                        warp_id        <= next_warp;
                        imem_req_valid <= 1'b1;
                        state          <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (imem_req_ready) begin
                        imem_req_valid <= 1'b0;
                    end
                    if (imem_rsp_valid) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (uop.opcode == HALT) begin
                        active[warp_id] <= 1'b0;
                    end
                    if ((uop.opcode == LW) || (uop.opcode == SW)) begin
                        dmem_req_valid <= 1'b1;
                        state          <= S_MEM;
                    end else begin
                        state <= S_PICK;
                    end
                end
                S_MEM: begin
                    // A store is done at its handshake, a load waits for its data
                    if (dmem_req_ready) begin
                        dmem_req_valid <= 1'b0;
                        if (uop.opcode == SW) begin
                            state <= S_PICK;
                        end
                    end
                    if (load_wb) begin
                        state <= S_PICK;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                pcs[i] <= start_pc;
            end
        end else if (exec_en) begin
            pcs[warp_id] <= branch_taken ? branch_target : pcs[warp_id] + 1'b1;
        end
    end

endmodule

//--- src/decode.sv
/*
 * Instruction register and field decode.
 * The decoded operation holds from the cycle after the fetch response
 * until the next one.
 */
module decode (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fetch_done,
    input  logic [core_pkg::XLEN-1:0] instr,
    output isa_pkg::uop_t             uop
);
    import isa_pkg::*;

    instr_u instr_q;

    // Reset leaves an ADD to r0, which changes nothing
    always_ff @(posedge clk) begin
        if (reset) begin
            instr_q <= '0;
        end else if (fetch_done) begin
            instr_q <= instr;
        end
    end

    assign uop.opcode = instr_q.r_fmt.opcode;
    assign uop.rd     = instr_q.r_fmt.rd;
    assign uop.rs1    = instr_q.r_fmt.rs1;
    assign uop.rs2    = instr_q.r_fmt.rs2;
    assign uop.imm    = ILEN'(instr_q.i_fmt.imm);

endmodule

//--- src/exec_unit.sv
/*
 * Per-warp register files and the single-thread datapath.
 * Registers are not cleared by reset or launch, so programs must
 * write a register before reading it.
 */
module exec_unit #(
    parameter int NUM_WARPS = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [$clog2(NUM_WARPS)-1:0] warp_id,
    input  logic                         exec_en,
    input  logic                         load_wb,
    input  isa_pkg::uop_t                uop,
    input  logic [core_pkg::XLEN-1:0]    load_data,
    input  logic [core_pkg::ADDR_W-1:0]  pc,
    output logic                         branch_taken,
    output logic [core_pkg::ADDR_W-1:0]  branch_target,
    output core_pkg::mem_req_t           dmem_req
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [XLEN-1:0] regs [NUM_WARPS][8];
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] rd_val;
    logic [XLEN-1:0] alu_result;
    logic            alu_we;

    // r0 is never written, so its reads are forced to zero here
    assign rs1_val = (uop.rs1 == 3'd0) ? '0 : regs[warp_id][uop.rs1];
    assign rs2_val = (uop.rs2 == 3'd0) ? '0 : regs[warp_id][uop.rs2];
    assign rd_val  = (uop.rd == 3'd0) ? '0 : regs[warp_id][uop.rd];

    always_comb begin
        alu_we = exec_en;
        case (uop.opcode)
            ADD:     alu_result = rs1_val + rs2_val;
            SUB:     alu_result = rs1_val - rs2_val;
            AND:     alu_result = rs1_val & rs2_val;
            ADDI:    alu_result = rs1_val + uop.imm;
            WID:     alu_result = XLEN'(warp_id);
            default: begin
                alu_result = '0;
                alu_we     = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset && (uop.rd != 3'd0)) begin
            if (load_wb) begin
                regs[warp_id][uop.rd] <= load_data;
            end else if (alu_we) begin
                regs[warp_id][uop.rd] <= alu_result;
            end
        end
    end

    assign branch_taken  = (uop.opcode == BNEZ) && (rd_val != '0);
    assign branch_target = pc + 1'b1 + uop.imm[ADDR_W-1:0];

    // The address wraps at the memory width
    assign dmem_req = mem_req_t'{
        addr:  rs1_val[ADDR_W-1:0] + uop.imm[ADDR_W-1:0],
        write: (uop.opcode == SW),
        wdata: rd_val
    };

endmodule

//--- src/perf_counters.sv
/*
 * Fetch, load and store counters with latency accumulators.
 * Latency counts each cycle a request is pending, starting the cycle
 * after its handshake. All counters clear on launch.
 */
module perf_counters (
    input  logic            clk,
    input  logic            reset,
    input  logic            launch,
    input  logic            imem_req_fire,
    input  logic            imem_rsp_valid,
    input  logic            dmem_req_fire,
    input  logic            dmem_req_write,
    input  logic            dmem_rsp_valid,
    output core_pkg::perf_t perf
);
    import core_pkg::*;

    logic [PERF_W-1:0] ifetch_pending;
    logic [PERF_W-1:0] load_pending;
    logic              load_fire;
    logic              store_fire;

    assign load_fire  = dmem_req_fire && !dmem_req_write;
    assign store_fire = dmem_req_fire && dmem_req_write;

    always_ff @(posedge clk) begin
        if (reset || launch) begin
            perf           <= '0;
            ifetch_pending <= '0;
            load_pending   <= '0;
        end else begin
            ifetch_pending <= ifetch_pending + PERF_W'(imem_req_fire) - PERF_W'(imem_rsp_valid);
            load_pending   <= load_pending + PERF_W'(load_fire) - PERF_W'(dmem_rsp_valid);

            perf.ifetches       <= perf.ifetches + PERF_W'(imem_req_fire);
            perf.loads          <= perf.loads + PERF_W'(load_fire);
            perf.stores         <= perf.stores + PERF_W'(store_fire);
            perf.ifetch_latency <= perf.ifetch_latency + ifetch_pending;
            perf.load_latency   <= perf.load_latency + load_pending;
        end
    end

endmodule

//--- src/mini_core.sv
/*
 * Mini multi-warp core. Instruction and data memory sit outside.
 * Each bus has one request outstanding, and responses cannot be stalled.
 */
module mini_core #(
    parameter int NUM_WARPS = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dcr_wr_valid,
    input  core_pkg::dcr_wr_t         dcr_wr,
    output logic                      imem_req_valid,
    output core_pkg::mem_req_t        imem_req,
    input  logic                      imem_req_ready,
    input  logic                      imem_rsp_valid,
    input  logic [core_pkg::XLEN-1:0] imem_rsp_data,
    output logic                      dmem_req_valid,
    output core_pkg::mem_req_t        dmem_req,
    input  logic                      dmem_req_ready,
    input  logic                      dmem_rsp_valid,
    input  logic [core_pkg::XLEN-1:0] dmem_rsp_data,
    output logic                      busy,
    output core_pkg::perf_t           perf
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [ADDR_W-1:0]            start_pc;
    logic [NUM_WARPS-1:0]         warp_mask;
    logic                         launch;
    uop_t                         uop;
    logic                         branch_taken;
    logic [ADDR_W-1:0]            branch_target;
    logic                         fetch_done;
    logic                         exec_en;
    logic                         load_wb;
    logic [$clog2(NUM_WARPS)-1:0] warp_id;
    logic                         imem_req_fire;
    logic                         dmem_req_fire;

    assign imem_req_fire = imem_req_valid && imem_req_ready;
    assign dmem_req_fire = dmem_req_valid && dmem_req_ready;

    dcr_regs #(.NUM_WARPS(NUM_WARPS)) dcr_regs0 (
        .clk          (clk),
        .reset        (reset),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr       (dcr_wr),
        .start_pc     (start_pc),
        .warp_mask    (warp_mask),
        .launch       (launch)
    );

    warp_sched #(.NUM_WARPS(NUM_WARPS)) warp_sched0 (
        .clk            (clk),
        .reset          (reset),
        .start_pc       (start_pc),
        .warp_mask      (warp_mask),
        .launch         (launch),
        .uop            (uop),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .imem_req_valid (imem_req_valid),
        .imem_req       (imem_req),
        .imem_req_ready (imem_req_ready),
        .imem_rsp_valid (imem_rsp_valid),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req_ready (dmem_req_ready),
        .dmem_rsp_valid (dmem_rsp_valid),
        .fetch_done     (fetch_done),
        .exec_en        (exec_en),
        .load_wb        (load_wb),
        .warp_id        (warp_id),
        .busy           (busy)
    );

    decode decode0 (
        .clk        (clk),
        .reset      (reset),
        .fetch_done (fetch_done),
        .instr      (imem_rsp_data),
        .uop        (uop)
    );

    // The fetch address still holds the current warp's PC during execute
    exec_unit #(.NUM_WARPS(NUM_WARPS)) exec_unit0 (
        .clk           (clk),
        .reset         (reset),
        .warp_id       (warp_id),
        .exec_en       (exec_en),
        .load_wb       (load_wb),
        .uop           (uop),
        .load_data     (dmem_rsp_data),
        .pc            (imem_req.addr),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .dmem_req      (dmem_req)
    );

    perf_counters perf_counters0 (
        .clk            (clk),
        .reset          (reset),
        .launch         (launch),
        .imem_req_fire  (imem_req_fire),
        .imem_rsp_valid (imem_rsp_valid),
        .dmem_req_fire  (dmem_req_fire),
        .dmem_req_write (dmem_req.write),
        .dmem_rsp_valid (dmem_rsp_valid),
        .perf           (perf)
    );

endmodule

//--- tb/mini_core_sva.sv
/*
 * Protocol checks on the warp scheduler, bound into every instance.
 * The FETCH encoding below must follow the scheduler's state enum.
 */
module mini_core_sva (
    input logic               clk,
    input logic               reset,
    input logic [2:0]         state,
    input logic               imem_req_valid,
    input core_pkg::mem_req_t imem_req,
    input logic               imem_req_ready,
    input logic               dmem_req_valid,
    input logic               dmem_req_ready,
    input logic               busy
);
    localparam logic [2:0] FETCH = 3'd2;

    // A waiting request keeps its valid and its content
    a_imem_hold: assert property (@(posedge clk) disable iff (reset)
        imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_req))
        else $error("imem request changed before it was accepted");

    a_dmem_hold: assert property (@(posedge clk) disable iff (reset)
        dmem_req_valid && !dmem_req_ready |=> dmem_req_valid)
        else $error("dmem request dropped before it was accepted");

    a_reset_idle: assert property (@(posedge clk)
        reset |=> !busy && !imem_req_valid && !dmem_req_valid)
        else $error("core not idle after reset");

    a_no_dmem_in_fetch: assert property (@(posedge clk) disable iff (reset)
        (state == FETCH) |-> !dmem_req_valid)
        else $error("data request made while a fetch is pending");

endmodule

bind warp_sched mini_core_sva sva0 (
    .clk            (clk),
    .reset          (reset),
    .state          (state),
    .imem_req_valid (imem_req_valid),
    .imem_req       (imem_req),
    .imem_req_ready (imem_req_ready),
    .dmem_req_valid (dmem_req_valid),
    .dmem_req_ready (dmem_req_ready),
    .busy           (busy)
);

//--- tb/tb_mini_core.sv
/*
 * Testbench for the mini core. Cases come from tb/core_cases.txt.
 * Memories are modelled here with random ready and response delays.
 * Responses arrive at least one cycle after the request handshake.
 */
module tb_mini_core;
    import core_pkg::*;

    localparam int NUM_WARPS   = 4;
    localparam int CASE_CYCLES = 3000;

    logic            clk;
    logic            reset;
    logic            dcr_wr_valid;
    dcr_wr_t         dcr_wr;
    logic            imem_req_valid;
    mem_req_t        imem_req;
    logic            imem_req_ready;
    logic            imem_rsp_valid;
    logic [XLEN-1:0] imem_rsp_data;
    logic            dmem_req_valid;
    mem_req_t        dmem_req;
    logic            dmem_req_ready;
    logic            dmem_rsp_valid;
    logic [XLEN-1:0] dmem_rsp_data;
    logic            busy;
    perf_t           perf;

    logic [XLEN-1:0] imem [256];
    logic [XLEN-1:0] dmem [256];
    mem_req_t        exp_stores [$];
    int              seed = 90665;
    int              num_cases = 0;

    mini_core #(.NUM_WARPS(NUM_WARPS)) dut0 (
        .clk            (clk),
        .reset          (reset),
        .dcr_wr_valid   (dcr_wr_valid),
        .dcr_wr         (dcr_wr),
        .imem_req_valid (imem_req_valid),
        .imem_req       (imem_req),
        .imem_req_ready (imem_req_ready),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_data  (imem_rsp_data),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req       (dmem_req),
        .dmem_req_ready (dmem_req_ready),
        .dmem_rsp_valid (dmem_rsp_valid),
        .dmem_rsp_data  (dmem_rsp_data),
        .busy           (busy),
        .perf           (perf)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("error at time %0t: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_store(input mem_req_t act, input mem_req_t exp);
        if (act !== exp) begin
            fail_run($sformatf("store to %h data %h, expected store to %h data %h",
                act.addr, act.wdata, exp.addr, exp.wdata));
        end
    endtask

    // With no request ever made nothing can be pending, so its latency stays zero
    task automatic check_perf(input perf_t act, input perf_t exp);
        if (act.ifetches !== exp.ifetches || act.loads !== exp.loads ||
            act.stores !== exp.stores) begin
            fail_run($sformatf("counts fetch %0d load %0d store %0d, expected %0d %0d %0d",
                act.ifetches, act.loads, act.stores, exp.ifetches, exp.loads, exp.stores));
        end else if (act.ifetch_latency < act.ifetches || act.load_latency < act.loads) begin
            fail_run($sformatf("latency fetch %0d load %0d is below its count",
                act.ifetch_latency, act.load_latency));
        end else if ((act.ifetches == 0 && act.ifetch_latency !== 0) ||
                     (act.loads == 0 && act.load_latency !== 0)) begin
            fail_run($sformatf("latency fetch %0d load %0d without any request",
                act.ifetch_latency, act.load_latency));
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            fail_run($sformatf("%s is %b, expected %b", what, act, exp));
        end
    endtask

    function automatic int rand_delay();
        return $random(seed) & 3;
    endfunction

    // Each step ends one time unit after a rising edge
    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic fill_memories();
        for (int a = 0; a < 256; a++) begin
            imem[a] = 16'h8000 | 16'(a);
            dmem[a] = {8'(a), ~8'(a)};
        end
    endtask

    task automatic write_dcr(input logic [DCR_ADDR_W-1:0] addr, input int data);
        dcr_wr_valid = 1'b1;
        dcr_wr.addr  = addr;
        dcr_wr.data  = 16'(data);
        step_cycles(1);
        dcr_wr_valid = 1'b0;
    endtask

    task automatic run_case(input int mask, input int pc);
        write_dcr(DCR_START_PC, pc);
        write_dcr(DCR_WARP_MASK, mask);
        write_dcr(DCR_LAUNCH, 0);
        while (!busy) step_cycles(1);
        while (busy) step_cycles(1);
        step_cycles(1);
    endtask

    initial begin : imem_model
        logic [ADDR_W-1:0] addr;
        forever begin
            step_cycles(1);
            if (imem_req_valid) begin
                step_cycles(rand_delay());
                imem_req_ready = 1'b1;
                addr = imem_req.addr;
                step_cycles(1);
                imem_req_ready = 1'b0;
                step_cycles(rand_delay());
                imem_rsp_valid = 1'b1;
                imem_rsp_data  = imem[addr];
                step_cycles(1);
                imem_rsp_valid = 1'b0;
            end
        end
    end

    initial begin : dmem_model
        mem_req_t req;
        forever begin
            step_cycles(1);
            if (dmem_req_valid) begin
                step_cycles(rand_delay());
                dmem_req_ready = 1'b1;
                req = dmem_req;
                step_cycles(1);
                dmem_req_ready = 1'b0;
                if (!req.write) begin
                    step_cycles(rand_delay());
                    dmem_rsp_valid = 1'b1;
                    dmem_rsp_data  = dmem[req.addr];
                    step_cycles(1);
                    dmem_rsp_valid = 1'b0;
                end else if (exp_stores.size() == 0) begin
                    fail_run("the core made a store that the case does not expect");
                end else begin
                    check_store(req, exp_stores.pop_front());
                    dmem[req.addr] = req.wdata;
                end
            end
        end
    end

    initial begin : watchdog
        wait (num_cases > 0);
        repeat (CASE_CYCLES * num_cases) @(posedge clk);
        $display("timeout: the cases did not finish within %0d cycles",
            CASE_CYCLES * num_cases);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : runner
        int       fd;
        int       code;
        int       a;
        int       w;
        int       mask;
        int       pc;
        int       nf;
        int       nl;
        int       ns;
        string    line;
        perf_t    exp_perf;
        reset          = 1'b1;
        dcr_wr_valid   = 1'b0;
        dcr_wr         = '0;
        imem_req_ready = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp_data  = '0;
        dmem_req_ready = 1'b0;
        dmem_rsp_valid = 1'b0;
        dmem_rsp_data  = '0;
        mask = 0;
        pc   = 0;
        fill_memories();

        fd = $fopen("tb/core_cases.txt", "r");
        if (fd == 0) fail_run("the case file tb/core_cases.txt could not be opened");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line[0] == "E") num_cases++;
        end
        $fclose(fd);
        if (num_cases == 0) fail_run("the case file holds no cases");

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        step_cycles(2);
        check_flag(busy, 1'b0, "busy before launch");
        check_flag(imem_req_valid, 1'b0, "imem_req_valid before launch");
        check_flag(dmem_req_valid, 1'b0, "dmem_req_valid before launch");
        check_perf(perf, '0);

        fd = $fopen("tb/core_cases.txt", "r");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0) begin
                case (line[0])
                    "P": begin
                        code = $sscanf(line, "P %h %h", a, w);
                        imem[a[7:0]] = 16'(w);
                    end
                    "D": begin
                        code = $sscanf(line, "D %h %h", a, w);
                        dmem[a[7:0]] = 16'(w);
                    end
                    "L": code = $sscanf(line, "L %h %h", mask, pc);
                    "S": begin
                        code = $sscanf(line, "S %h %h", a, w);
                        exp_stores.push_back(mem_req_t'{addr: 8'(a), write: 1'b1,
                            wdata: 16'(w)});
                    end
                    "C": code = $sscanf(line, "C %d %d %d", nf, nl, ns);
                    "E": begin
                        run_case(mask, pc);
                        if (exp_stores.size() != 0) begin
                            fail_run("the case ended with expected stores still missing");
                        end
                        exp_perf          = '0;
                        exp_perf.ifetches = 32'(nf);
                        exp_perf.loads    = 32'(nl);
                        exp_perf.stores   = 32'(ns);
                        check_perf(perf, exp_perf);
                        fill_memories();
                    end
                    default: ;
                endcase
            end
        end
        $fclose(fd);

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- tb/core_cases.txt
# P addr word | D addr word | L warp_mask start_pc | S store_addr store_data (in order)
# C fetches loads stores (decimal) | E runs the case; other values are hex
P 00 7200
P 01 3445
P 02 0688
P 03 5650
P 04 8000
L f 00
S 10 0005
S 11 0007
S 12 0009
S 13 000b
C 20 0 4
E
P 20 7200
P 21 4448
P 22 1688
P 23 5658
P 24 8000
D 08 1000
D 09 2222
D 0a 3333
D 0b 0444
L f 20
S 18 1000
S 19 2221
S 1a 3331
S 1b 0441
C 20 4 4
E
P 00 7200
P 01 3443
P 02 3600
P 03 36c1
P 04 34bf
P 05 643d
P 06 5650
P 07 8000
L 5 00
S 10 0003
S 12 0005
C 34 0 2
E

//--- filelist.f
src/isa_pkg.sv
src/core_pkg.sv
src/dcr_regs.sv
src/warp_sched.sv
src/decode.sv
src/exec_unit.sv
src/perf_counters.sv
src/mini_core.sv
tb/mini_core_sva.sv
tb/tb_mini_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mini_core
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) tb/core_cases.txt
	./$(BIN) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
